//--- files.f
verilog/rvIsaPkg.sv
verilog/decodeCtrlPkg.sv
verilog/fieldExtract.sv
verilog/controlGen.sv
verilog/decodeQueue.sv
verilog/instrDecodePipe.sv
dv/instrDecodePipe_assertions.sv
dv/instrDecodePipeTb.sv

//--- Makefile
# Verilator build and run of the decoder testbench

TOP = instrDecodePipeTb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "^ALL TESTS PASSED$$" $(LOG) || { echo "simulation failed"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

//--- dv/instrDecodePipeTb.sv
`timescale 1ns/1ps

module instrDecodePipeTb;

    import rvIsaPkg::*;
    import decodeCtrlPkg::*;

    localparam int WAIT_LIMIT = 60;

    // one expected output item
    typedef struct packed {
        logic [ALU_CTRL_W-1:0] aluCtrl;
        logic                  aluSrc;
        logic                  resultSrc;
        logic [REG_ADDR_W-1:0] rdAddr1;
        logic [REG_ADDR_W-1:0] rdAddr2;
        logic [REG_ADDR_W-1:0] wrAddr;
        logic                  regWrite;
        logic                  memWrite;
        logic [IMM_OP_W-1:0]   immOp;
        logic [IMM_SEL_W-1:0]  immSrc;
        logic [PC_W-1:0]       pc;
        logic                  pcSrc;
    } expItem_t;

    logic clk = 1'b0;
    logic rst;
    logic inValid;
    instrWord_u instruction;
    logic [PC_W-1:0] pcNext;
    logic zero;
    logic inCredit;
    logic outCredit = 1'b0;
    logic outValid;
    logic [ALU_CTRL_W-1:0] aluCtrl;
    logic aluSrc;
    logic resultSrc;
    logic [REG_ADDR_W-1:0] rdAddr1;
    logic [REG_ADDR_W-1:0] rdAddr2;
    logic [REG_ADDR_W-1:0] wrAddr;
    logic regWrite;
    logic memWrite;
    logic [IMM_OP_W-1:0] immOp;
    logic [IMM_SEL_W-1:0] immSrc;
    logic [PC_W-1:0] pc;
    logic pcSrc;

    expItem_t expQ [$];
    int errors = 0;
    int testErrStart = 0;
    int passCount = 0;
    // producer credits spent and returned
    int creditsSpent = 0;
    int creditsBack = 0;
    // consumer credits granted, and items taken
    int granted = 0;
    int consumed = 0;
    int grantLimit = 0;
    int outValidCount = 0;
    int inCreditCount = 0;

    instrDecodePipe i_instrDecodePipe (.*);

    always #2 clk = ~clk;

    // expected outputs straight from the class table
    function automatic expItem_t predict(logic [31:0] w, logic [PC_W-1:0] pcn, logic z);
        expItem_t e;
        logic [2:0] f3;
        f3 = w[14:12];
        e = '0;
        e.aluSrc = 1'b1;
        e.immOp = w[31:7];
        case (w[6:0])
            OP_REG: begin
                e.rdAddr1 = w[19:15];
                e.rdAddr2 = w[24:20];
                e.wrAddr = w[11:7];
                e.regWrite = 1'b1;
                e.aluSrc = 1'b0;
                e.aluCtrl = {w[30], f3};
            end
            OP_IMM: begin
                e.rdAddr1 = w[19:15];
                e.wrAddr = w[11:7];
                e.regWrite = 1'b1;
                e.aluCtrl = {(f3 == 3'b101) && w[30], f3};
            end
            OP_LOAD: begin
                e.rdAddr1 = w[19:15];
                e.wrAddr = w[11:7];
                e.regWrite = 1'b1;
                e.resultSrc = 1'b1;
                e.immSrc = IMM_L;
            end
            OP_STORE: begin
                e.rdAddr1 = w[19:15];
                e.rdAddr2 = w[24:20];
                e.memWrite = 1'b1;
                e.resultSrc = 1'b1;
                e.immSrc = IMM_S;
            end
            OP_JAL: begin
                e.rdAddr1 = w[19:15];
                e.wrAddr = w[11:7];
                e.regWrite = 1'b1;
                e.pcSrc = 1'b1;
                e.immSrc = IMM_J;
            end
            OP_LUI, OP_AUIPC: begin
                e.wrAddr = w[11:7];
                e.regWrite = 1'b1;
                e.immSrc = IMM_U;
                if (w[6:0] == OP_AUIPC) e.pc = pcn - 32'd4;
            end
            OP_BRANCH: begin
                e.rdAddr1 = w[19:15];
                e.rdAddr2 = w[24:20];
                e.aluSrc = 1'b0;
                e.immSrc = IMM_B;
                // taken on zero for eq, lt, ltu and on not zero for the rest
                case (f3)
                    F3_BEQ, F3_BNE: e.aluCtrl = ALU_SUB;
                    F3_BLT, F3_BGE: e.aluCtrl = ALU_SLT;
                    F3_BLTU, F3_BGEU: e.aluCtrl = ALU_SLTU;
                    default: begin
                        e = '0;
                        e.aluSrc = 1'b1;
                    end
                endcase
                if (f3 != 3'b010 && f3 != 3'b011) e.pcSrc = f3[0] ? !z : z;
            end
            default: begin
                e = '0;
                e.aluSrc = 1'b1;
            end
        endcase
        return e;
    endfunction

    task automatic checkCtrl(input string name, input logic [IMM_OP_W-1:0] got, exp);
        if (got !== exp) begin
            $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic checkPc(input string name, input logic [PC_W-1:0] got, exp);
        if (got !== exp) begin
            $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic checkCount(input string name, input int got, exp);
        if (got != exp) begin
            $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // consumer hands out a credit only for items it knows are coming
    always @(posedge clk) begin
        #1;
        if (granted < grantLimit && granted - consumed < expQ.size()) begin
            outCredit = 1'b1;
            granted++;
        end else begin
            outCredit = 1'b0;
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin : monitor
        expItem_t e;
        if (!rst) begin
            if (inCredit) begin
                creditsBack++;
                inCreditCount++;
            end
            if (outValid) begin
                outValidCount++;
                consumed++;
                if (expQ.size() == 0) begin
                    $display("outValid seen with no item outstanding");
                    errors++;
                end else begin
                    e = expQ.pop_front();
                    checkCtrl("aluCtrl", IMM_OP_W'(aluCtrl), IMM_OP_W'(e.aluCtrl));
                    checkCtrl("aluSrc", IMM_OP_W'(aluSrc), IMM_OP_W'(e.aluSrc));
                    checkCtrl("resultSrc", IMM_OP_W'(resultSrc), IMM_OP_W'(e.resultSrc));
                    checkCtrl("rdAddr1", IMM_OP_W'(rdAddr1), IMM_OP_W'(e.rdAddr1));
                    checkCtrl("rdAddr2", IMM_OP_W'(rdAddr2), IMM_OP_W'(e.rdAddr2));
                    checkCtrl("wrAddr", IMM_OP_W'(wrAddr), IMM_OP_W'(e.wrAddr));
                    checkCtrl("regWrite", IMM_OP_W'(regWrite), IMM_OP_W'(e.regWrite));
                    checkCtrl("memWrite", IMM_OP_W'(memWrite), IMM_OP_W'(e.memWrite));
                    checkCtrl("immOp", immOp, e.immOp);
                    checkCtrl("immSrc", IMM_OP_W'(immSrc), IMM_OP_W'(e.immSrc));
                    checkCtrl("pcSrc", IMM_OP_W'(pcSrc), IMM_OP_W'(e.pcSrc));
                    checkPc("pc", pc, e.pc);
                end
            end
        end
    end

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    // waits for a producer credit, then drives one item for one cycle
    task automatic sendItem(input logic [31:0] w, input logic [PC_W-1:0] pcn, input logic z);
        int n;
        n = 0;
        while (QUEUE_DEPTH - creditsSpent + creditsBack == 0 && n < WAIT_LIMIT) begin
            nextCycle();
            n++;
        end
        if (n == WAIT_LIMIT) begin
            $display("timeout waiting for a producer credit");
            errors++;
        end else begin
            inValid = 1'b1;
            instruction = w;
            pcNext = pcn;
            zero = z;
            expQ.push_back(predict(w, pcn, z));
            creditsSpent++;
            nextCycle();
            inValid = 1'b0;
        end
    endtask

    task automatic waitDrained();
        int n;
        n = 0;
        while (expQ.size() != 0 && n < WAIT_LIMIT) begin
            nextCycle();
            n++;
        end
        if (expQ.size() != 0) begin
            $display("timeout with %0d items still expected", expQ.size());
            errors++;
        end
    endtask

    task automatic endTest(input int num, input string name);
        if (errors == testErrStart) begin
            passCount++;
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - testErrStart);
        end
        testErrStart = errors;
    endtask

    task automatic aluTest();
        logic [31:0] w;
        for (int i = 0; i < 6; i++) begin
            w = $urandom;
            w[6:0] = OP_REG;
            w[31:25] = {1'b0, w[30], 5'b0};
            sendItem(w, $urandom, 1'b0);
            w = $urandom;
            w[6:0] = OP_IMM;
            sendItem(w, $urandom, 1'b1);
        end
        // srai keeps bit 30, addi with the same bit set loses it
        w = $urandom;
        w[6:0] = OP_IMM;
        w[14:12] = 3'b101;
        w[31:25] = 7'b0100000;
        sendItem(w, $urandom, 1'b0);
        w[14:12] = 3'b000;
        sendItem(w, $urandom, 1'b0);
        waitDrained();
    endtask

    task automatic memTest();
        logic [31:0] w;
        logic [OPCODE_W-1:0] ops [4];
        ops = '{OP_LOAD, OP_STORE, OP_LUI, OP_AUIPC};
        for (int i = 0; i < 8; i++) begin
            w = $urandom;
            w[6:0] = ops[i % 4];
            sendItem(w, $urandom, w[20]);
        end
        waitDrained();
    endtask

    task automatic branchTest();
        logic [31:0] w;
        logic [FUNCT3_W-1:0] conds [6];
        conds = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        for (int c = 0; c < 6; c++) begin
            for (int z = 0; z < 2; z++) begin
                w = $urandom;
                w[6:0] = OP_BRANCH;
                w[14:12] = conds[c];
                sendItem(w, $urandom, z[0]);
            end
        end
        // jal jumps whatever the flag says
        for (int z = 0; z < 2; z++) begin
            w = $urandom;
            w[6:0] = OP_JAL;
            sendItem(w, $urandom, z[0]);
        end
        waitDrained();
    endtask

    task automatic nopTest();
        logic [31:0] w;
        w = $urandom;
        w[6:0] = 7'b1111111;
        sendItem(w, $urandom, 1'b0);
        w[6:0] = 7'b1110011;
        sendItem(w, $urandom, 1'b1);
        for (int z = 0; z < 2; z++) begin
            w = $urandom;
            w[6:0] = OP_BRANCH;
            w[14:12] = 3'b010 | 3'(z);
            sendItem(w, $urandom, z[0]);
        end
        waitDrained();
    endtask

    task automatic backPressureTest();
        logic [31:0] w;
        int startValid;
        int startCredit;
        int n;
        grantLimit = granted;
        startValid = outValidCount;
        startCredit = inCreditCount;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            w = $urandom;
            w[6:0] = OP_REG;
            sendItem(w, $urandom, 1'b0);
        end
        // nothing may leave while the consumer holds back
        repeat (10) nextCycle();
        checkCount("outValid while held", outValidCount - startValid, 0);
        checkCount("inCredit while held", inCreditCount - startCredit, 0);
        for (int k = 0; k < QUEUE_DEPTH; k++) begin
            grantLimit++;
            n = 0;
            while (outValidCount - startValid < k + 1 && n < WAIT_LIMIT) begin
                nextCycle();
                n++;
            end
            if (n == WAIT_LIMIT) begin
                $display("timeout waiting for outValid after a credit");
                errors++;
            end
            repeat (3) nextCycle();
            checkCount("outValid per credit", outValidCount - startValid, k + 1);
        end
        // every one of the held items was popped and returned its slot
        checkCount("inCredit pulses", inCreditCount - startCredit, QUEUE_DEPTH);
        checkCount("items left", expQ.size(), 0);
        grantLimit = 1 << 30;
    endtask

    initial begin
        void'($urandom(32'h5188efeb));
        rst = 1'b1;
        inValid = 1'b0;
        instruction = '0;
        pcNext = '0;
        zero = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        grantLimit = 1 << 30;
        aluTest();
        endTest(1, "alu register and immediate");
        memTest();
        endTest(2, "load store lui auipc");
        branchTest();
        endTest(3, "branches and jal");
        nopTest();
        endTest(4, "no-op decode");
        backPressureTest();
        endTest(5, "back-pressure");
        errors += i_instrDecodePipe.protocolChecks.failCount;
        $display("tests 5, passed %0d, errors %0d", passCount, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- dv/instrDecodePipe_assertions.sv
`timescale 1ns/1ps

module instrDecodePipeAssertions (
    input logic clk,
    input logic rst,
    input logic inValid,
    input logic inCredit,
    input logic outCredit,
    input logic outValid
);

    import decodeCtrlPkg::*;

    // credits the producer holds, mirrored from the port traffic
    logic [CREDIT_W-1:0] prodCredits;
    // credits the DUT holds on the output side
    logic [CREDIT_W-1:0] outCreditCnt;
    int                  failCount = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            prodCredits  <= CREDIT_W'(QUEUE_DEPTH);
            outCreditCnt <= '0;
        end else begin
            prodCredits  <= prodCredits - CREDIT_W'(inValid) + CREDIT_W'(inCredit);
            outCreditCnt <= outCreditCnt + CREDIT_W'(outCredit) - CREDIT_W'(outValid);
        end
    end

    // producer side
    assert property (@(posedge clk) disable iff (rst) inValid |-> prodCredits != '0)
        else begin
            $error("inValid sent with no producer credit");
            failCount++;
        end

    // consumer side
    assert property (@(posedge clk) disable iff (rst) outValid |-> outCreditCnt != '0)
        else begin
            $error("outValid with no output credit held");
            failCount++;
        end

    // every pop frees exactly one slot
    assert property (@(posedge clk) disable iff (rst) inCredit == outValid)
        else begin
            $error("inCredit and outValid differ");
            failCount++;
        end

    assert property (@(posedge clk) rst |=> !outValid && !inCredit)
        else begin
            $error("outValid or inCredit high right after reset");
            failCount++;
        end

endmodule

bind instrDecodePipe instrDecodePipeAssertions protocolChecks (
    .clk, .rst, .inValid, .inCredit, .outCredit, .outValid
);

//--- verilog/instrDecodePipe.sv
`timescale 1ns/1ps

module instrDecodePipe (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 inValid,
    input  rvIsaPkg::instrWord_u                 instruction,
    input  logic [decodeCtrlPkg::PC_W-1:0]       pcNext,
    input  logic                                 zero,
    output logic                                 inCredit,
    input  logic                                 outCredit,
    output logic                                 outValid,
    output logic [decodeCtrlPkg::ALU_CTRL_W-1:0] aluCtrl,
    output logic                                 aluSrc,
    output logic                                 resultSrc,
    output logic [rvIsaPkg::REG_ADDR_W-1:0]      rdAddr1,
    output logic [rvIsaPkg::REG_ADDR_W-1:0]      rdAddr2,
    output logic [rvIsaPkg::REG_ADDR_W-1:0]      wrAddr,
    output logic                                 regWrite,
    output logic                                 memWrite,
    output logic [decodeCtrlPkg::IMM_OP_W-1:0]   immOp,
    output logic [decodeCtrlPkg::IMM_SEL_W-1:0]  immSrc,
    output logic [decodeCtrlPkg::PC_W-1:0]       pc,
    output logic                                 pcSrc
);

    import rvIsaPkg::*;
    import decodeCtrlPkg::*;

    // stage 1 to stage 2
    logic                  s1Valid;
    instrWord_u            s1Instr;
    logic [PC_W-1:0]       s1PcNext;
    logic                  s1Zero;
    logic [CLS_W-1:0]      s1Class;

    // stage 2 to queue
    logic                  s2Valid;
    logic [PC_W-1:0]       s2Pc;
    logic [ALU_CTRL_W-1:0] s2AluCtrl;
    logic                  s2AluSrc;
    logic                  s2ResultSrc;
    logic [REG_ADDR_W-1:0] s2RdAddr1;
    logic [REG_ADDR_W-1:0] s2RdAddr2;
    logic [REG_ADDR_W-1:0] s2WrAddr;
    logic                  s2RegWrite;
    logic                  s2MemWrite;
    logic [IMM_OP_W-1:0]   s2ImmOp;
    logic [IMM_SEL_W-1:0]  s2ImmSrc;
    logic                  s2PcSrc;

    // register and classify
    fieldExtract i_fieldExtract (
        .clk, .rst, .inValid, .instruction, .pcNext, .zero,
        .s1Valid, .s1Instr, .s1PcNext, .s1Zero, .s1Class
    );

    // control word and branch resolve
    controlGen i_controlGen (
        .clk, .rst, .s1Valid, .s1Instr, .s1PcNext, .s1Zero, .s1Class,
        .s2Valid, .s2Pc, .s2AluCtrl, .s2AluSrc, .s2ResultSrc,
        .s2RdAddr1, .s2RdAddr2, .s2WrAddr, .s2RegWrite, .s2MemWrite,
        .s2ImmOp, .s2ImmSrc, .s2PcSrc
    );

    // output queue, credits on both sides
    decodeQueue i_decodeQueue (
        .clk, .rst, .s2Valid, .s2Pc, .s2AluCtrl, .s2AluSrc, .s2ResultSrc,
        .s2RdAddr1, .s2RdAddr2, .s2WrAddr, .s2RegWrite, .s2MemWrite,
        .s2ImmOp, .s2ImmSrc, .s2PcSrc,
        .outCredit, .inCredit, .outValid,
        .aluCtrl, .aluSrc, .resultSrc, .rdAddr1, .rdAddr2, .wrAddr,
        .regWrite, .memWrite, .immOp, .immSrc, .pc, .pcSrc
    );

endmodule

//--- verilog/decodeQueue.sv
`timescale 1ns/1ps

module decodeQueue (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 s2Valid,
    input  logic [decodeCtrlPkg::PC_W-1:0]       s2Pc,
    input  logic [decodeCtrlPkg::ALU_CTRL_W-1:0] s2AluCtrl,
    input  logic                                 s2AluSrc,
    input  logic                                 s2ResultSrc,
    input  logic [rvIsaPkg::REG_ADDR_W-1:0]      s2RdAddr1,
    input  logic [rvIsaPkg::REG_ADDR_W-1:0]      s2RdAddr2,
    input  logic [rvIsaPkg::REG_ADDR_W-1:0]      s2WrAddr,
    input  logic                                 s2RegWrite,
    input  logic                                 s2MemWrite,
    input  logic [decodeCtrlPkg::IMM_OP_W-1:0]   s2ImmOp,
    input  logic [decodeCtrlPkg::IMM_SEL_W-1:0]  s2ImmSrc,
    input  logic                                 s2PcSrc,
    input  logic                                 outCredit,
    output logic                                 inCredit,
    output logic                                 outValid,
    output logic [decodeCtrlPkg::ALU_CTRL_W-1:0] aluCtrl,
    output logic                                 aluSrc,
    output logic                                 resultSrc,
    output logic [rvIsaPkg::REG_ADDR_W-1:0]      rdAddr1,
    output logic [rvIsaPkg::REG_ADDR_W-1:0]      rdAddr2,
    output logic [rvIsaPkg::REG_ADDR_W-1:0]      wrAddr,
    output logic                                 regWrite,
    output logic                                 memWrite,
    output logic [decodeCtrlPkg::IMM_OP_W-1:0]   immOp,
    output logic [decodeCtrlPkg::IMM_SEL_W-1:0]  immSrc,
    output logic [decodeCtrlPkg::PC_W-1:0]       pc,
    output logic                                 pcSrc
);

    import rvIsaPkg::*;
    import decodeCtrlPkg::*;

    // all decoded fields of one item, packed side by side
    logic [ALU_CTRL_W+3*REG_ADDR_W+IMM_OP_W+IMM_SEL_W+PC_W+4:0] wrEntry;
    logic [$bits(wrEntry)-1:0]          mem [QUEUE_DEPTH];
    logic [$clog2(QUEUE_DEPTH)-1:0]     wrPtr;
    logic [$clog2(QUEUE_DEPTH)-1:0]     rdPtr;
    // items held, 0 up to QUEUE_DEPTH
    logic [CREDIT_W-1:0]                count;
    // credits granted by the consumer and not yet spent
    logic [CREDIT_W-1:0]                outCredits;
    logic                               pop;

    assign wrEntry = {s2AluCtrl, s2AluSrc, s2ResultSrc, s2RdAddr1, s2RdAddr2, s2WrAddr,
                      s2RegWrite, s2MemWrite, s2ImmOp, s2ImmSrc, s2Pc, s2PcSrc};

    // one item leaves per cycle while both an item and a credit are held
    assign pop      = (count != '0) && (outCredits != '0);
    assign outValid = pop;
    // the freed slot goes straight back to the producer
    assign inCredit = pop;

    // head entry drives the outputs
    assign {aluCtrl, aluSrc, resultSrc, rdAddr1, rdAddr2, wrAddr,
            regWrite, memWrite, immOp, immSrc, pc, pcSrc} = mem[rdPtr];

    // producer credits keep a push from ever landing on a full queue
    always_ff @(posedge clk) begin
        if (s2Valid) begin
            mem[wrPtr] <= wrEntry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            count      <= '0;
            outCredits <= '0;
        end else begin
            wrPtr      <= wrPtr + $bits(wrPtr)'(s2Valid);
            rdPtr      <= rdPtr + $bits(rdPtr)'(pop);
            count      <= count + CREDIT_W'(s2Valid) - CREDIT_W'(pop);
            outCredits <= outCredits + CREDIT_W'(outCredit) - CREDIT_W'(pop);
        end
    end

endmodule

//--- verilog/controlGen.sv
`timescale 1ns/1ps

module controlGen (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 s1Valid,
    input  rvIsaPkg::instrWord_u                 s1Instr,
    input  logic [decodeCtrlPkg::PC_W-1:0]       s1PcNext,
    input  logic                                 s1Zero,
    input  logic [decodeCtrlPkg::CLS_W-1:0]      s1Class,
    output logic                                 s2Valid,
    output logic [decodeCtrlPkg::PC_W-1:0]       s2Pc,
    output logic [decodeCtrlPkg::ALU_CTRL_W-1:0] s2AluCtrl,
    output logic                                 s2AluSrc,
    output logic                                 s2ResultSrc,
    output logic [rvIsaPkg::REG_ADDR_W-1:0]      s2RdAddr1,
    output logic [rvIsaPkg::REG_ADDR_W-1:0]      s2RdAddr2,
    output logic [rvIsaPkg::REG_ADDR_W-1:0]      s2WrAddr,
    output logic                                 s2RegWrite,
    output logic                                 s2MemWrite,
    output logic [decodeCtrlPkg::IMM_OP_W-1:0]   s2ImmOp,
    output logic [decodeCtrlPkg::IMM_SEL_W-1:0]  s2ImmSrc,
    output logic                                 s2PcSrc
);

    import rvIsaPkg::*;
    import decodeCtrlPkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            s2Valid <= 1'b0;
        end else begin
            s2Valid <= s1Valid;
        end
    end

    // control word for the class found in stage 1
    always_ff @(posedge clk) begin
        // no-op values, each class overrides what it needs
        s2AluCtrl   <= ALU_ADD;
        s2AluSrc    <= 1'b1;
        s2ResultSrc <= 1'b0;
        s2RdAddr1   <= '0;
        s2RdAddr2   <= '0;
        s2WrAddr    <= '0;
        s2RegWrite  <= 1'b0;
        s2MemWrite  <= 1'b0;
        s2ImmOp     <= '0;
        s2ImmSrc    <= IMM_I;
        s2Pc        <= '0;
        s2PcSrc     <= 1'b0;
        // raw field for the sign extend block, every real class
        if (s1Class != CLS_NOP) begin
            s2ImmOp <= {s1Instr.u.upperImm, s1Instr.u.rd};
        end
        case (s1Class)
            CLS_REG: begin
                s2RdAddr1  <= s1Instr.r.rs1;
                s2RdAddr2  <= s1Instr.r.rs2;
                s2WrAddr   <= s1Instr.r.rd;
                s2RegWrite <= 1'b1;
                s2AluSrc   <= 1'b0;
                // funct7[5] is instruction bit 30
                s2AluCtrl  <= {s1Instr.r.funct7[5], s1Instr.r.funct3};
            end
            CLS_IMM: begin
                s2RdAddr1  <= s1Instr.r.rs1;
                s2WrAddr   <= s1Instr.r.rd;
                s2RegWrite <= 1'b1;
                // bit 30 only picks srai over srli, elsewhere it is immediate data
                s2AluCtrl  <= {(s1Instr.r.funct3 == 3'b101) && s1Instr.r.funct7[5],
                               s1Instr.r.funct3};
            end
            CLS_LOAD: begin
                s2RdAddr1   <= s1Instr.r.rs1;
                s2WrAddr    <= s1Instr.r.rd;
                s2RegWrite  <= 1'b1;
                s2ResultSrc <= 1'b1;
                s2ImmSrc    <= IMM_L;
            end
            CLS_STORE: begin
                // rs1 is the base, rs2 the store data
                s2RdAddr1   <= s1Instr.r.rs1;
                s2RdAddr2   <= s1Instr.r.rs2;
                s2MemWrite  <= 1'b1;
                s2ResultSrc <= 1'b1;
                s2ImmSrc    <= IMM_S;
            end
            CLS_JAL: begin
                s2RdAddr1  <= s1Instr.r.rs1;
                s2WrAddr   <= s1Instr.r.rd;
                s2RegWrite <= 1'b1;
                s2PcSrc    <= 1'b1;
                s2ImmSrc   <= IMM_J;
            end
            CLS_LUI: begin
                // x0 plus the upper immediate
                s2WrAddr   <= s1Instr.u.rd;
                s2RegWrite <= 1'b1;
                s2ImmSrc   <= IMM_U;
            end
            CLS_AUIPC: begin
                s2WrAddr   <= s1Instr.u.rd;
                s2RegWrite <= 1'b1;
                s2ImmSrc   <= IMM_U;
                // pcNext is already one word ahead
                s2Pc       <= s1PcNext - PC_W'(4);
            end
            CLS_BRANCH: begin
                s2RdAddr1 <= s1Instr.r.rs1;
                s2RdAddr2 <= s1Instr.r.rs2;
                s2AluSrc  <= 1'b0;
                s2ImmSrc  <= IMM_B;
                // compare op and taken rule per condition
                // zero carries the result of the compare
                case (s1Instr.r.funct3)
                    F3_BEQ: begin
                        s2AluCtrl <= ALU_SUB;
                        s2PcSrc   <= s1Zero;
                    end
                    F3_BNE: begin
                        s2AluCtrl <= ALU_SUB;
                        s2PcSrc   <= !s1Zero;
                    end
                    F3_BLT: begin
                        s2AluCtrl <= ALU_SLT;
                        s2PcSrc   <= s1Zero;
                    end
                    F3_BGE: begin
                        s2AluCtrl <= ALU_SLT;
                        s2PcSrc   <= !s1Zero;
                    end
                    F3_BLTU: begin
                        s2AluCtrl <= ALU_SLTU;
                        s2PcSrc   <= s1Zero;
                    end
                    default: begin
                        // bgeu, the other codes never reach this stage
                        s2AluCtrl <= ALU_SLTU;
                        s2PcSrc   <= !s1Zero;
                    end
                endcase
            end
            default: begin
                // no-op, defaults stand
            end
        endcase
    end

endmodule

//--- verilog/fieldExtract.sv
`timescale 1ns/1ps

module fieldExtract (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              inValid,
    input  rvIsaPkg::instrWord_u              instruction,
    input  logic [decodeCtrlPkg::PC_W-1:0]    pcNext,
    input  logic                              zero,
    output logic                              s1Valid,
    output rvIsaPkg::instrWord_u              s1Instr,
    output logic [decodeCtrlPkg::PC_W-1:0]    s1PcNext,
    output logic                              s1Zero,
    output logic [decodeCtrlPkg::CLS_W-1:0]   s1Class
);

    import rvIsaPkg::*;
    import decodeCtrlPkg::*;

    // class of the incoming word, before the register
    logic [CLS_W-1:0] inClass;

    // opcode lookup
    // anything not listed falls through to the no-op class
    always_comb begin
        inClass = CLS_NOP;
        case (instruction.r.opcode)
            OP_REG:    inClass = CLS_REG;
            OP_IMM:    inClass = CLS_IMM;
            OP_LOAD:   inClass = CLS_LOAD;
            OP_STORE:  inClass = CLS_STORE;
            OP_JAL:    inClass = CLS_JAL;
            OP_LUI:    inClass = CLS_LUI;
            OP_AUIPC:  inClass = CLS_AUIPC;
            OP_BRANCH: begin
                // only the six defined conditions are real branches
                case (instruction.r.funct3)
                    F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU: begin
                        inClass = CLS_BRANCH;
                    end
                    default: begin
                        inClass = CLS_NOP;
                    end
                endcase
            end
            default: begin
                inClass = CLS_NOP;
            end
        endcase
    end

    // stage valid
    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid <= 1'b0;
        end else begin
            s1Valid <= inValid;
        end
    end

    // word, pc and flag travel with the class into stage 2
    always_ff @(posedge clk) begin
        s1Instr  <= instruction;
        s1PcNext <= pcNext;
        s1Zero   <= zero;
        s1Class  <= inClass;
    end

endmodule

//--- verilog/decodeCtrlPkg.sv
package decodeCtrlPkg;

    // ALU control, bit 3 is instruction bit 30, low bits are funct3
    localparam int ALU_CTRL_W = 4;
    localparam logic [ALU_CTRL_W-1:0] ALU_ADD  = 4'b0000;
    localparam logic [ALU_CTRL_W-1:0] ALU_SUB  = 4'b1000;
    localparam logic [ALU_CTRL_W-1:0] ALU_SLT  = 4'b0010;
    localparam logic [ALU_CTRL_W-1:0] ALU_SLTU = 4'b0011;

    // immediate select for the sign extend block
    localparam int IMM_SEL_W = 3;
    localparam logic [IMM_SEL_W-1:0] IMM_I = 3'b000;
    localparam logic [IMM_SEL_W-1:0] IMM_U = 3'b001;
    localparam logic [IMM_SEL_W-1:0] IMM_S = 3'b010;
    localparam logic [IMM_SEL_W-1:0] IMM_J = 3'b011;
    localparam logic [IMM_SEL_W-1:0] IMM_L = 3'b100;
    localparam logic [IMM_SEL_W-1:0] IMM_B = 3'b111;

    // raw immediate field, instruction bits 31:7
    localparam int IMM_OP_W = 25;
    localparam int PC_W     = 32;

    // instruction class found in stage 1
    localparam int CLS_W = 4;
    localparam logic [CLS_W-1:0] CLS_NOP    = 4'd0;
    localparam logic [CLS_W-1:0] CLS_REG    = 4'd1;
    localparam logic [CLS_W-1:0] CLS_IMM    = 4'd2;
    localparam logic [CLS_W-1:0] CLS_LOAD   = 4'd3;
    localparam logic [CLS_W-1:0] CLS_STORE  = 4'd4;
    localparam logic [CLS_W-1:0] CLS_JAL    = 4'd5;
    localparam logic [CLS_W-1:0] CLS_LUI    = 4'd6;
    localparam logic [CLS_W-1:0] CLS_AUIPC  = 4'd7;
    localparam logic [CLS_W-1:0] CLS_BRANCH = 4'd8;

    // output queue and its credit counters
    localparam int QUEUE_DEPTH = 4;
    localparam int CREDIT_W    = 3;

endpackage

//--- verilog/rvIsaPkg.sv
package rvIsaPkg;

    // base integer instruction word
    localparam int INSTR_W    = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;

    // major opcodes kept by the decoder
    localparam logic [OPCODE_W-1:0] OP_REG    = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OP_IMM    = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OP_LOAD   = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OP_STORE  = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OP_JAL    = 7'b1101111;
    localparam logic [OPCODE_W-1:0] OP_LUI    = 7'b0110111;
    localparam logic [OPCODE_W-1:0] OP_AUIPC  = 7'b0010111;
    localparam logic [OPCODE_W-1:0] OP_BRANCH = 7'b1100011;

    // branch conditions in funct3
    // 010 and 011 are not assigned
    localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_BLT  = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_BGE  = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_BGEU = 3'b111;

    // one instruction word, two readings of the same bits
    typedef union packed {
        // register format, also gives rs1/rs2/funct3 for I, S and B types
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [FUNCT3_W-1:0]   funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [OPCODE_W-1:0]   opcode;
        } r;
        // upper immediate format
        // upperImm joined to rd is the raw immediate field, bits 31:7
        struct packed {
            logic [INSTR_W-REG_ADDR_W-OPCODE_W-1:0] upperImm;
            logic [REG_ADDR_W-1:0]                  rd;
            logic [OPCODE_W-1:0]                    opcode;
        } u;
    } instrWord_u;

endpackage
